//--- axis2axi_wr_vectors.txt
// Start byte address, length in words, first data word and expected bursts, all in hex
// Lengths run from 001 to 100, one transfer per line
0000 010 a5000000 1
0040 001 11110000 1
0ffc 001 22220000 1
// Last byte lands in the next 4 KB page
0ff0 008 33330000 2
2ffc 002 44440000 2
// Full length, inside a page and split
1000 100 55550000 1
3c00 100 66660000 1
1f00 100 77770000 2
1ffc 100 88880000 2
// Longer runs that fill the input FIFO
3000 020 99990000 1
2800 040 aaaa0000 1
0800 0ff bbbb0000 1

//--- verilog.f
axis_wr_pkg.sv
axis_wr_fifo.sv
axis2axi_wr.sv
axi_wr_mem.sv
axis2axi_wr_top.sv
tb_axis2axi_wr.sv

//--- Bender.yml
package:
  name: axis2axi_wr

sources:
  - files:
      - axis_wr_pkg.sv
      - axis_wr_fifo.sv
      - axis2axi_wr.sv
      - axi_wr_mem.sv
      - axis2axi_wr_top.sv
  - target: test
    files:
      - tb_axis2axi_wr.sv

//--- tb_axis2axi_wr.sv
/*
 * Self-checking testbench for the stream to AXI write subsystem
 * Replays transfers from the vector file and reads the memory back
 */
`timescale 1ns/1ps

module tb_axis2axi_wr;

   localparam int MAX_VEC     = 32;
   localparam int STALL_LIMIT = 2000;
   localparam int BUSY_LIMIT  = 4000;

   typedef logic [axis_wr_pkg::ADDR_W-1:0] addr_t;
   typedef logic [axis_wr_pkg::DATA_W-1:0] data_t;
   typedef logic [axis_wr_pkg::BCNT_W-1:0] bcnt_t;

   // One transfer as read from the vector file
   typedef struct packed {
      addr_t                       addr;
      logic [axis_wr_pkg::LEN_W:0] len;
      data_t                       first;
      bcnt_t                       bursts;
   } xfer_t;

   logic                        clk_i;
   logic                        arst_n_i;
   addr_t                       addr_i;
   logic [axis_wr_pkg::LEN_W:0] length_i;
   logic                        start_i;
   logic                        busy_o;
   data_t                       s_data_i;
   logic                        s_valid_i;
   logic                        s_ready_o;
   addr_t                       rd_addr_i;
   data_t                       rd_data_o;
   bcnt_t                       burst_count_o;

   // Four entries per transfer
   logic [31:0] vec_mem [4*MAX_VEC];

   integer seed;
   int     errors;
   int     timeouts;
   int     checks;
   bit     aborted;

   axis2axi_wr_top dut_i (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .addr_i       (addr_i),
      .length_i     (length_i),
      .start_i      (start_i),
      .busy_o       (busy_o),
      .s_data_i     (s_data_i),
      .s_valid_i    (s_valid_i),
      .s_ready_o    (s_ready_o),
      .rd_addr_i    (rd_addr_i),
      .rd_data_o    (rd_data_o),
      .burst_count_o(burst_count_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      aborted = 1'b1;
      $display("Timeout while waiting for %s, remaining transfers skipped", what);
   endtask

   task automatic start_transfer(input xfer_t x);
      @(posedge clk_i);
      addr_i   <= x.addr;
      length_i <= x.len;
      start_i  <= 1'b1;
      @(posedge clk_i);
      start_i  <= 1'b0;
   endtask

   task automatic stream_words(input xfer_t x);
      int sent;
      int stall;
      bit pending;
      bit busy_seen;
      bit extra_sent;
      sent       = 0;
      stall      = 0;
      pending    = 1'b0;
      busy_seen  = 1'b0;
      extra_sent = x.len < 2;
      while (sent < x.len && !aborted) begin
         @(posedge clk_i);
         // An offered word holds until it is taken
         if (!pending) begin
            s_valid_i <= ($random(seed) & 3) != 0;
            s_data_i  <= x.first + data_t'(sent);
         end
         // Second start halfway through, the writer is busy and drops it
         if (!extra_sent && busy_seen && sent >= x.len / 2) begin
            start_i    <= 1'b1;
            addr_i     <= x.addr ^ 14'h0800;
            length_i   <= 9'd3;
            extra_sent = 1'b1;
         end else begin
            start_i <= 1'b0;
         end
         @(negedge clk_i);
         busy_seen = busy_o;
         pending   = s_valid_i && !s_ready_o;
         if (s_valid_i && s_ready_o) begin
            sent++;
         end
         stall = pending ? stall + 1 : 0;
         if (stall > STALL_LIMIT) begin
            report_timeout("s_ready_o to rise");
         end
      end
      @(posedge clk_i);
      s_valid_i <= 1'b0;
      start_i   <= 1'b0;
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      while (busy_o && cycles < BUSY_LIMIT) begin
         @(negedge clk_i);
         cycles++;
      end
      if (busy_o) begin
         report_timeout("busy_o to fall");
      end
   endtask

   // Word k of a transfer sits at address plus 4k
   task automatic check_memory(input xfer_t x);
      int k;
      for (k = 0; k < x.len; k++) begin
         @(posedge clk_i);
         rd_addr_i <= x.addr + addr_t'(4 * k);
         @(negedge clk_i);
         compare_value($sformatf("rd_data_o[0x%04h]", rd_addr_i), rd_data_o,
                       x.first + data_t'(k));
      end
   endtask

   initial begin
      xfer_t x;
      int    idx;
      bcnt_t count_before;
      bcnt_t bursts_seen;
      seed      = 32'h9bc7;
      errors    = 0;
      timeouts  = 0;
      checks    = 0;
      aborted   = 1'b0;
      arst_n_i  = 1'b0;
      addr_i    = '0;
      length_i  = '0;
      start_i   = 1'b0;
      s_data_i  = '0;
      s_valid_i = 1'b0;
      rd_addr_i = '0;
      for (idx = 0; idx < 4 * MAX_VEC; idx++) begin
         vec_mem[idx] = '0;
      end
      $readmemh("axis2axi_wr_vectors.txt", vec_mem);

      repeat (5) @(posedge clk_i);
      arst_n_i <= 1'b1;
      @(negedge clk_i);
      compare_value("busy_o", busy_o, 1'b0);
      compare_value("s_ready_o", s_ready_o, 1'b0);
      compare_value("burst_count_o", burst_count_o, '0);

      // A zero length marks the end of the loaded vectors
      idx = 0;
      while (idx < MAX_VEC && vec_mem[4 * idx + 1] != '0 && !aborted) begin
         x.addr   = vec_mem[4 * idx][axis_wr_pkg::ADDR_W-1:0];
         x.len    = vec_mem[4 * idx + 1][axis_wr_pkg::LEN_W:0];
         x.first  = vec_mem[4 * idx + 2];
         x.bursts = vec_mem[4 * idx + 3][axis_wr_pkg::BCNT_W-1:0];
         count_before = burst_count_o;
         start_transfer(x);
         stream_words(x);
         if (!aborted) begin
            wait_idle();
         end
         if (!aborted) begin
            bursts_seen = burst_count_o - count_before;
            compare_value("burst_count_o", bursts_seen, x.bursts);
            check_memory(x);
         end
         idx++;
      end
      if (idx == 0) begin
         errors++;
         $display("No transfers were loaded from the vector file");
      end

      $display("Transfers: %0d, checks: %0d, errors: %0d, timeouts: %0d",
               idx, checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- axis2axi_wr_top.sv
/*
 * Stream to AXI write subsystem with input FIFO, burst writer and memory target
 */
`timescale 1ns/1ps

module axis2axi_wr_top (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic [axis_wr_pkg::ADDR_W-1:0] addr_i,
   input  logic [axis_wr_pkg::LEN_W:0]    length_i,
   input  logic                           start_i,
   output logic                           busy_o,
   input  logic [axis_wr_pkg::DATA_W-1:0] s_data_i,
   input  logic                           s_valid_i,
   output logic                           s_ready_o,
   input  logic [axis_wr_pkg::ADDR_W-1:0] rd_addr_i,
   output logic [axis_wr_pkg::DATA_W-1:0] rd_data_o,
   output logic [axis_wr_pkg::BCNT_W-1:0] burst_count_o
);

   // FIFO to writer stream
   logic [axis_wr_pkg::DATA_W-1:0] fifo_data;
   logic                           fifo_valid;
   logic                           fifo_ready;

   // Writer to memory AXI channels
   axis_wr_pkg::aw_chan_t aw;
   axis_wr_pkg::w_chan_t  w;
   logic                  awready;
   logic                  wready;
   logic                  bvalid;

   axis_wr_fifo fifo_i (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (s_data_i),
      .valid_i (s_valid_i),
      .ready_o (s_ready_o),
      .data_o  (fifo_data),
      .valid_o (fifo_valid),
      .ready_i (fifo_ready)
   );

   axis2axi_wr writer_i (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .addr_i   (addr_i),
      .length_i (length_i),
      .start_i  (start_i),
      .busy_o   (busy_o),
      .s_data_i (fifo_data),
      .s_valid_i(fifo_valid),
      .s_ready_o(fifo_ready),
      .aw_o     (aw),
      .awready_i(awready),
      .w_o      (w),
      .wready_i (wready),
      .bvalid_i (bvalid)
   );

   axi_wr_mem mem_i (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .aw_i         (aw),
      .awready_o    (awready),
      .w_i          (w),
      .wready_o     (wready),
      .bvalid_o     (bvalid),
      .rd_addr_i    (rd_addr_i),
      .rd_data_o    (rd_data_o),
      .burst_count_o(burst_count_o)
   );

endmodule

//--- axi_wr_mem.sv
/*
 * AXI4 write target with a word memory, a completed burst counter
 * and a combinational read-back port
 */
`timescale 1ns/1ps

module axi_wr_mem (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  axis_wr_pkg::aw_chan_t          aw_i,
   output logic                           awready_o,
   input  axis_wr_pkg::w_chan_t           w_i,
   output logic                           wready_o,
   output logic                           bvalid_o,
   input  logic [axis_wr_pkg::ADDR_W-1:0] rd_addr_i,
   output logic [axis_wr_pkg::DATA_W-1:0] rd_data_o,
   output logic [axis_wr_pkg::BCNT_W-1:0] burst_count_o
);

   logic [axis_wr_pkg::DATA_W-1:0] mem_q [axis_wr_pkg::MEM_WORDS];

   logic                           open_q;
   logic                           bvalid_q;
   logic [axis_wr_pkg::ADDR_W-1:0] wr_addr_q;
   logic [axis_wr_pkg::BCNT_W-1:0] burst_cnt_q;

   logic aw_take;
   logic w_take;
   logic w_end;

   // One burst at a time
   assign awready_o = ~open_q;
   assign wready_o  = open_q;

   assign aw_take = aw_i.valid & awready_o;
   assign w_take  = w_i.valid & wready_o;

   // Burst closes on WLAST
   assign w_end = w_take & w_i.last;

   assign bvalid_o      = bvalid_q;
   assign burst_count_o = burst_cnt_q;
   assign rd_data_o     = mem_q[rd_addr_i[axis_wr_pkg::MEM_IDX_W+1:2]];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         open_q      <= 1'b0;
         bvalid_q    <= 1'b0;
         burst_cnt_q <= '0;
      end else begin
         if (aw_take) begin
            open_q <= 1'b1;
         end else if (w_end) begin
            open_q <= 1'b0;
         end
         bvalid_q <= w_end;   // bready is tied high on the writer
         if (bvalid_q) begin
            burst_cnt_q <= burst_cnt_q + 1'b1;
         end
      end
   end

   // Burst address advances one word per beat
   always_ff @(posedge clk_i) begin
      if (aw_take) begin
         wr_addr_q <= aw_i.addr;
      end else if (w_take) begin
         wr_addr_q <= wr_addr_q + 3'd4;
      end
   end

   always_ff @(posedge clk_i) begin
      if (w_take) begin
         mem_q[wr_addr_q[axis_wr_pkg::MEM_IDX_W+1:2]] <= w_i.data;
      end
   end

endmodule

//--- axis2axi_wr.sv
/*
 * Burst writer that turns a word stream into AXI4 INCR write bursts
 * Splits a request in two when it would cross a 4 KB page
 */
`timescale 1ns/1ps

module axis2axi_wr (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic [axis_wr_pkg::ADDR_W-1:0] addr_i,
   input  logic [axis_wr_pkg::LEN_W:0]    length_i,
   input  logic                           start_i,
   output logic                           busy_o,
   input  logic [axis_wr_pkg::DATA_W-1:0] s_data_i,
   input  logic                           s_valid_i,
   output logic                           s_ready_o,
   output axis_wr_pkg::aw_chan_t          aw_o,
   input  logic                           awready_i,
   output axis_wr_pkg::w_chan_t           w_o,
   input  logic                           wready_i,
   input  logic                           bvalid_i
);

   axis_wr_pkg::wr_state_e state_q;
   axis_wr_pkg::wr_state_e state_d;

   // Address channel registers
   logic                           aw_valid_q;
   logic                           aw_valid_d;
   logic [axis_wr_pkg::ADDR_W-1:0] aw_addr_q;
   logic [axis_wr_pkg::ADDR_W-1:0] aw_addr_d;
   logic [axis_wr_pkg::LEN_W-1:0]  aw_len_q;
   logic [axis_wr_pkg::LEN_W-1:0]  aw_len_d;

   // Data channel registers
   logic                           w_valid_q;
   logic                           w_valid_d;
   logic                           w_last_q;
   logic                           w_last_d;
   logic [axis_wr_pkg::DATA_W-1:0] w_data_q;

   // Words left for the second burst
   logic [axis_wr_pkg::LEN_W:0]    remain_q;
   logic [axis_wr_pkg::LEN_W:0]    remain_d;
   logic [axis_wr_pkg::LEN_W-1:0]  beat_cnt_q;
   logic                           beat_clr;
   logic                           take;
   logic                           last_beat;

   // Page split arithmetic on the start request
   logic [axis_wr_pkg::ADDR_W:0]   len_bytes;
   logic [axis_wr_pkg::ADDR_W:0]   last_addr;
   logic [axis_wr_pkg::PAGE_BIT:0] page_bytes;
   logic [axis_wr_pkg::LEN_W:0]    len_m1;
   logic [axis_wr_pkg::LEN_W-1:0]  split_len;
   logic                           crosses;

   assign len_bytes = {{(axis_wr_pkg::ADDR_W - axis_wr_pkg::LEN_W - 2){1'b0}}, length_i, 2'b00};
   assign last_addr = {1'b0, addr_i} + len_bytes - 1'b1;
   assign crosses   = addr_i[axis_wr_pkg::PAGE_BIT] != last_addr[axis_wr_pkg::PAGE_BIT];

   // Bytes left up to the next page boundary
   assign page_bytes = {1'b1, {axis_wr_pkg::PAGE_BIT{1'b0}}}
                     - {1'b0, addr_i[axis_wr_pkg::PAGE_BIT-1:0]};
   assign split_len  = page_bytes[axis_wr_pkg::LEN_W+1:2] - 1'b1;
   assign len_m1     = length_i - 1'b1;

   assign busy_o    = state_q != axis_wr_pkg::WAIT_START;
   assign s_ready_o = wready_i && (state_q == axis_wr_pkg::TRANSF_DATA);
   assign take      = s_valid_i & s_ready_o;
   assign last_beat = beat_cnt_q == aw_len_q;

   assign aw_o = '{addr: aw_addr_q, len: aw_len_q, valid: aw_valid_q};
   assign w_o  = '{data: w_data_q, last: w_last_q, valid: w_valid_q};

   always_comb begin
      state_d    = state_q;
      aw_valid_d = 1'b0;
      aw_addr_d  = aw_addr_q;
      aw_len_d   = aw_len_q;
      remain_d   = remain_q;
      w_valid_d  = 1'b0;
      w_last_d   = 1'b0;
      beat_clr   = 1'b0;

      case (state_q)
         axis_wr_pkg::WAIT_START: begin
            if (start_i) begin
               // Full length fits the page, else stop at the boundary
               aw_len_d   = crosses ? split_len : len_m1[axis_wr_pkg::LEN_W-1:0];
               aw_addr_d  = addr_i;
               aw_valid_d = 1'b1;
               remain_d   = length_i - {1'b0, aw_len_d} - 1'b1;
               state_d    = axis_wr_pkg::START_BURST;
            end
         end

         axis_wr_pkg::START_BURST: begin
            if (awready_i) begin
               state_d = axis_wr_pkg::TRANSF_DATA;
            end else begin
               aw_valid_d = 1'b1;
            end
         end

         axis_wr_pkg::TRANSF_DATA: begin
            w_valid_d = s_valid_i;
            if (s_valid_i && last_beat) begin
               w_last_d = 1'b1;
               if (wready_i) begin
                  state_d = axis_wr_pkg::WAIT_BRESP;
               end
            end
         end

         axis_wr_pkg::WAIT_BRESP: begin
            if (bvalid_i) begin
               beat_clr = 1'b1;
               if (remain_q == '0) begin
                  state_d = axis_wr_pkg::WAIT_START;
               end else begin
                  // Second burst begins on the next page
                  aw_len_d   = remain_q[axis_wr_pkg::LEN_W-1:0] - 1'b1;
                  aw_addr_d  = {aw_addr_q[axis_wr_pkg::ADDR_W-1:axis_wr_pkg::PAGE_BIT] + 1'b1,
                                {axis_wr_pkg::PAGE_BIT{1'b0}}};
                  aw_valid_d = 1'b1;
                  remain_d   = '0;
                  state_d    = axis_wr_pkg::START_BURST;
               end
            end
         end

         default: state_d = axis_wr_pkg::WAIT_START;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= axis_wr_pkg::WAIT_START;
         aw_valid_q <= 1'b0;
         w_valid_q  <= 1'b0;
         w_last_q   <= 1'b0;
         remain_q   <= '0;
         beat_cnt_q <= '0;
      end else begin
         state_q    <= state_d;
         aw_valid_q <= aw_valid_d;
         remain_q   <= remain_d;
         // W beat stays put while the target stalls
         if (wready_i) begin
            w_valid_q <= w_valid_d;
            w_last_q  <= w_last_d;
         end
         if (beat_clr) begin
            beat_cnt_q <= '0;
         end else if (take) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      aw_addr_q <= aw_addr_d;
      aw_len_q  <= aw_len_d;
      if (wready_i) begin
         w_data_q <= s_data_i;
      end
   end

endmodule

//--- axis_wr_fifo.sv
/*
 * Input stream FIFO with first-word-fall-through output
 * Accepts a write into a full buffer when a read frees the slot in the same cycle
 */
`timescale 1ns/1ps

module axis_wr_fifo (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic [axis_wr_pkg::DATA_W-1:0] data_i,
   input  logic                           valid_i,
   output logic                           ready_o,
   output logic [axis_wr_pkg::DATA_W-1:0] data_o,
   output logic                           valid_o,
   input  logic                           ready_i
);

   logic [axis_wr_pkg::DATA_W-1:0] buf_q [axis_wr_pkg::FIFO_DEPTH];

   axis_wr_pkg::fifo_ptr_t wr_ptr_q;
   axis_wr_pkg::fifo_ptr_t rd_ptr_q;
   axis_wr_pkg::fifo_cnt_t count_q;

   // Holds ready low until the first clock after reset
   logic run_q;
   logic full;
   logic push;
   logic pop;

   assign full    = count_q == axis_wr_pkg::fifo_cnt_t'(axis_wr_pkg::FIFO_DEPTH);
   assign ready_o = run_q & (~full | ready_i);
   assign valid_o = count_q != '0;
   assign data_o  = buf_q[rd_ptr_q];

   assign push = valid_i & ready_o;
   assign pop  = valid_o & ready_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         run_q    <= 1'b0;
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         run_q <= 1'b1;
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Occupancy only moves when one side is idle
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk_i) begin
      if (push) begin
         buf_q[wr_ptr_q] <= data_i;
      end
   end

endmodule

//--- axis_wr_pkg.sv
/*
 * Shared sizes, AXI write channel structs and burst writer states
 * for the stream to AXI write subsystem
 */
package axis_wr_pkg;

   // Bus and buffer sizes
   localparam int ADDR_W     = 14;
   localparam int DATA_W     = 32;
   localparam int LEN_W      = 8;
   localparam int FIFO_DEPTH = 16;
   localparam int MEM_WORDS  = 4096;
   localparam int BCNT_W     = 16;

   // AXI bursts may not cross a 4 KB page
   localparam int PAGE_BIT   = 12;

   // Derived widths, depth is a power of two so pointers wrap by themselves
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam int MEM_IDX_W  = $clog2(MEM_WORDS);

   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
   typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

   // Write address channel, size, burst type and ID are fixed
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
      logic              valid;
   } aw_chan_t;

   // Write data channel, strobes are always full
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
      logic              valid;
   } w_chan_t;

   typedef enum logic [1:0] {
      WAIT_START  = 2'd0,
      START_BURST = 2'd1,
      TRANSF_DATA = 2'd2,
      WAIT_BRESP  = 2'd3
   } wr_state_e;

endpackage
